//--- hdl/sha_cfg.svh
`ifndef SHA_CFG_SVH
`define SHA_CFG_SVH

// Register stages inside each compression round.
// Raise this when one round does not close timing in a single cycle.
`define SHA_ROUND_DEPTH 1

// Core latency covers two hashes of 64 rounds each plus the pad stage register.
`define SHA_CORE_LATENCY (128 * `SHA_ROUND_DEPTH + 1)

`endif

//--- hdl/sha_pkg.sv
package sha_pkg;

	// One SHA-256 word.
	typedef logic [31:0] word_t;

	// Working variables A to H, with A in the top word.
	typedef logic [255:0] hash_state_t;

	// Sixteen message words, with word 0 in the top word.
	typedef logic [511:0] msg_block_t;

	// Merkle tail, time and bits fields of the block header, in that order from the top.
	typedef logic [95:0] header_tail_t;

	localparam word_t K_TABLE [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Returns the round constant for round 0 to 63.
	function automatic word_t round_k(input int idx);
		return K_TABLE[idx];
	endfunction

	// Standard SHA-256 initial hash value.
	localparam hash_state_t SHA_IV = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

endpackage

//--- hdl/sha_round_stage.sv
`timescale 1ns/1ps
`include "sha_cfg.svh"

module sha_round_stage #(
	parameter int ROUND = 0,
	parameter bit EXPAND = 1'b0
) (
	input  logic                clk,
	input  sha_pkg::hash_state_t state_i,
	input  sha_pkg::msg_block_t  w_i,
	output sha_pkg::hash_state_t state_o,
	output sha_pkg::msg_block_t  w_o
);
	import sha_pkg::*;

	word_t a, b, c, d, e, f, g, h;
	word_t t1, t2;
	hash_state_t state_next;
	msg_block_t w_next;
	hash_state_t state_q [`SHA_ROUND_DEPTH];
	msg_block_t w_q [`SHA_ROUND_DEPTH];

	function automatic word_t big_sigma0(input word_t x);
		return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
	endfunction

	function automatic word_t big_sigma1(input word_t x);
		return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
	endfunction

	function automatic word_t small_sigma0(input word_t x);
		return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(input word_t x);
		return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ (x >> 10);
	endfunction

	assign {a, b, c, d, e, f, g, h} = state_i;

	// Word 0 of the window is always the message word for this round.
	assign t1 = h + big_sigma1(e) + ((e & f) ^ (~e & g)) + round_k(ROUND) + w_i[511:480];
	assign t2 = big_sigma0(a) + ((a & b) ^ (a & c) ^ (b & c));
	assign state_next = {t1 + t2, a, b, c, d + t1, e, f, g};

	if (EXPAND) begin : g_expand
		// From round 15 on, word k of the window holds W[t-16+k] for k above zero.
		// The next word goes in front and the consumed word moves to the back.
		word_t w_new;
		assign w_new = small_sigma1(w_i[31:0]) + w_i[191:160]
			+ small_sigma0(w_i[447:416]) + w_i[479:448];
		assign w_next = {w_new, w_i[447:0], w_i[511:480]};
	end else begin : g_rotate
		// The first rounds only rotate so that the history is in place for round 15.
		assign w_next = {w_i[479:0], w_i[511:480]};
	end

	always_ff @(posedge clk) begin
		state_q[0] <= state_next;
		w_q[0] <= w_next;
		for (int i = 1; i < `SHA_ROUND_DEPTH; i++) begin
			state_q[i] <= state_q[i-1];
			w_q[i] <= w_q[i-1];
		end
	end

	assign state_o = state_q[`SHA_ROUND_DEPTH-1];
	assign w_o = w_q[`SHA_ROUND_DEPTH-1];

endmodule

//--- hdl/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
	parameter int WIDTH = 1,
	parameter int DELAY = 1
) (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic [WIDTH-1:0] d_i,
	output logic [WIDTH-1:0] q_o
);

	logic [WIDTH-1:0] sr_q [DELAY];

	// Every stage clears on reset so no stale valid bit survives in flight.
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 0; i < DELAY; i++) begin
				sr_q[i] <= '0;
			end
		end else begin
			sr_q[0] <= d_i;
			for (int i = 1; i < DELAY; i++) begin
				sr_q[i] <= sr_q[i-1];
			end
		end
	end

	assign q_o = sr_q[DELAY-1];

endmodule

//--- hdl/sha_pad_stage.sv
`timescale 1ns/1ps

module sha_pad_stage (
	input  logic                 clk,
	input  sha_pkg::hash_state_t rounds_i,
	input  sha_pkg::hash_state_t midstate_i,
	output sha_pkg::msg_block_t  block_o
);
	import sha_pkg::*;

	// The single one bit that follows the message.
	localparam word_t PAD_ONE = 32'h8000_0000;

	// The first hash is 256 bits long.
	localparam word_t HASH_BITS = 32'd256;

	hash_state_t first_hash;

	// Feed-forward addition that completes the first hash.
	for (genvar k = 0; k < 8; k++) begin : g_add
		assign first_hash[32*k +: 32] = rounds_i[32*k +: 32] + midstate_i[32*k +: 32];
	end

	// The first hash fills words 0 to 7 and the padding fills the rest.
	always_ff @(posedge clk) begin
		block_o <= {first_hash, PAD_ONE, 192'd0, HASH_BITS};
	end

endmodule

//--- hdl/sha_standard_pipelined_core.sv
`timescale 1ns/1ps
`include "sha_cfg.svh"

module sha_standard_pipelined_core (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 valid_i,
	input  sha_pkg::msg_block_t  words_i,
	input  sha_pkg::hash_state_t midstate_i,
	input  sha_pkg::word_t       nonce_i,
	input  logic                 last_i,
	output logic                 valid_o,
	output sha_pkg::hash_state_t hash_o,
	output sha_pkg::word_t       nonce_o,
	output logic                 last_o
);
	import sha_pkg::*;

	localparam int FIRST_LATENCY = 64 * `SHA_ROUND_DEPTH;
	localparam int SIDE_WIDTH = $bits(word_t) + 2;

	hash_state_t st1 [65];
	msg_block_t w1 [65];
	hash_state_t st2 [65];
	msg_block_t w2 [65];
	hash_state_t midstate_dly;
	logic [SIDE_WIDTH-1:0] side_in;
	logic [SIDE_WIDTH-1:0] side_out;

	assign st1[0] = midstate_i;
	assign w1[0] = words_i;

	// First hash over the second header chunk, seeded with the midstate.
	for (genvar i = 0; i < 64; i++) begin : g_hash1
		sha_round_stage #(
			.ROUND (i),
			.EXPAND(i >= 15)
		) u_round (
			.clk    (clk),
			.state_i(st1[i]),
			.w_i    (w1[i]),
			.state_o(st1[i+1]),
			.w_o    (w1[i+1])
		);
	end

	// The midstate has to line up with the end of the first hash for the feed-forward add.
	delay_line #(
		.WIDTH($bits(hash_state_t)),
		.DELAY(FIRST_LATENCY)
	) u_mid_dly (
		.clk    (clk),
		.rst_n_i(rst_n_i),
		.d_i    (midstate_i),
		.q_o    (midstate_dly)
	);

	sha_pad_stage u_pad (
		.clk       (clk),
		.rounds_i  (st1[64]),
		.midstate_i(midstate_dly),
		.block_o   (w2[0])
	);

	assign st2[0] = SHA_IV;

	// Second hash over the padded first hash.
	for (genvar i = 0; i < 64; i++) begin : g_hash2
		sha_round_stage #(
			.ROUND (i),
			.EXPAND(i >= 15)
		) u_round (
			.clk    (clk),
			.state_i(st2[i]),
			.w_i    (w2[i]),
			.state_o(st2[i+1]),
			.w_o    (w2[i+1])
		);
	end

	for (genvar k = 0; k < 8; k++) begin : g_final_add
		assign hash_o[32*k +: 32] = st2[64][32*k +: 32] + SHA_IV[32*k +: 32];
	end

	// Valid, nonce and last ride alongside the data for the whole core latency.
	assign side_in = {valid_i, nonce_i, last_i};

	delay_line #(
		.WIDTH(SIDE_WIDTH),
		.DELAY(`SHA_CORE_LATENCY)
	) u_side_dly (
		.clk    (clk),
		.rst_n_i(rst_n_i),
		.d_i    (side_in),
		.q_o    (side_out)
	);

	assign {valid_o, nonce_o, last_o} = side_out;

endmodule

//--- hdl/nonce_feeder.sv
`timescale 1ns/1ps

module nonce_feeder (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 start_i,
	input  sha_pkg::hash_state_t midstate_i,
	input  sha_pkg::header_tail_t tail_i,
	input  sha_pkg::word_t       nonce_start_i,
	input  sha_pkg::word_t       nonce_count_i,
	input  logic                 busy_i,
	output logic                 valid_o,
	output sha_pkg::msg_block_t  words_o,
	output sha_pkg::hash_state_t midstate_o,
	output sha_pkg::word_t       nonce_o,
	output logic                 last_o
);
	import sha_pkg::*;

	// Padding for an 80-byte header, which is 640 bits.
	localparam word_t PAD_ONE = 32'h8000_0000;
	localparam word_t HEADER_BITS = 32'd640;

	typedef enum logic {IDLE, ISSUE} feed_state_t;

	feed_state_t state_q;
	hash_state_t midstate_q;
	header_tail_t tail_q;
	word_t nonce_q;
	word_t left_q;
	logic accept;

	assign accept = start_i && !busy_i && (state_q == IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: if (accept) state_q <= ISSUE;
				ISSUE: if (left_q == '0) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// Left counts the nonces still to come after the current one.
	always_ff @(posedge clk) begin
		if (accept) begin
			midstate_q <= midstate_i;
			tail_q <= tail_i;
			nonce_q <= nonce_start_i;
			left_q <= (nonce_count_i == '0) ? '0 : nonce_count_i - 32'd1;
		end else if (state_q == ISSUE && left_q != '0) begin
			nonce_q <= nonce_q + 32'd1;
			left_q <= left_q - 32'd1;
		end
	end

	assign valid_o = (state_q == ISSUE);
	assign last_o = valid_o && (left_q == '0);
	assign words_o = {tail_q, nonce_q, PAD_ONE, 320'd0, HEADER_BITS};
	assign midstate_o = midstate_q;
	assign nonce_o = nonce_q;

endmodule

//--- hdl/hit_checker.sv
`timescale 1ns/1ps

module hit_checker (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 start_i,
	input  sha_pkg::word_t       target_i,
	input  logic                 valid_i,
	input  sha_pkg::hash_state_t hash_i,
	input  sha_pkg::word_t       nonce_i,
	input  logic                 last_i,
	output logic                 found_o,
	output sha_pkg::word_t       found_nonce_o,
	output sha_pkg::hash_state_t found_hash_o,
	output logic                 done_o,
	output logic                 busy_o
);
	import sha_pkg::*;

	word_t target_q;
	word_t h7;
	logic accept;

	assign accept = start_i && !busy_o;

	// H7 sits in the lowest word of the state.
	assign h7 = hash_i[31:0];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_o <= 1'b0;
			found_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			found_o <= valid_i && (h7 <= target_q);
			done_o <= valid_i && last_i;
			if (accept) begin
				busy_o <= 1'b1;
			end else if (done_o) begin
				// The job stays busy through the done cycle itself.
				busy_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) target_q <= target_i;
		if (valid_i) begin
			found_nonce_o <= nonce_i;
			found_hash_o <= hash_i;
		end
	end

endmodule

//--- hdl/miner_top.sv
`timescale 1ns/1ps

module miner_top (
	input  logic                  clk,
	input  logic                  rst_n_i,
	input  logic                  start_i,
	input  sha_pkg::hash_state_t  midstate_i,
	input  sha_pkg::header_tail_t tail_i,
	input  sha_pkg::word_t        nonce_start_i,
	input  sha_pkg::word_t        nonce_count_i,
	input  sha_pkg::word_t        target_i,
	output logic                  found_o,
	output sha_pkg::word_t        found_nonce_o,
	output sha_pkg::hash_state_t  found_hash_o,
	output logic                  done_o,
	output logic                  busy_o
);
	import sha_pkg::*;

	logic blk_valid;
	msg_block_t blk_words;
	hash_state_t blk_midstate;
	word_t blk_nonce;
	logic blk_last;
	logic out_valid;
	hash_state_t out_hash;
	word_t out_nonce;
	logic out_last;

	nonce_feeder u_feeder (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.start_i      (start_i),
		.midstate_i   (midstate_i),
		.tail_i       (tail_i),
		.nonce_start_i(nonce_start_i),
		.nonce_count_i(nonce_count_i),
		.busy_i       (busy_o),
		.valid_o      (blk_valid),
		.words_o      (blk_words),
		.midstate_o   (blk_midstate),
		.nonce_o      (blk_nonce),
		.last_o       (blk_last)
	);

	sha_standard_pipelined_core u_core (
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.valid_i   (blk_valid),
		.words_i   (blk_words),
		.midstate_i(blk_midstate),
		.nonce_i   (blk_nonce),
		.last_i    (blk_last),
		.valid_o   (out_valid),
		.hash_o    (out_hash),
		.nonce_o   (out_nonce),
		.last_o    (out_last)
	);

	hit_checker u_checker (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.start_i      (start_i),
		.target_i     (target_i),
		.valid_i      (out_valid),
		.hash_i       (out_hash),
		.nonce_i      (out_nonce),
		.last_i       (out_last),
		.found_o      (found_o),
		.found_nonce_o(found_nonce_o),
		.found_hash_o (found_hash_o),
		.done_o       (done_o),
		.busy_o       (busy_o)
	);

endmodule

//--- verification/sha_ref_model.svh
`ifndef SHA_REF_MODEL_SVH
`define SHA_REF_MODEL_SVH

// SHA-256 round constants.
localparam logic [31:0] K_ROUND [64] = '{
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
	32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
	32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
	32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
	32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
	32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
	32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
	32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
	32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
	32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
	32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

localparam logic [255:0] INIT_HASH = {
	32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
	32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
};

function automatic logic [31:0] rotr32(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// One compression of a 512-bit block, feed-forward add included.
function automatic logic [255:0] compress_block(input logic [255:0] chain,
		input logic [511:0] blk);
	logic [31:0] w [64];
	logic [31:0] v [8];
	logic [31:0] t1;
	logic [31:0] t2;
	logic [255:0] res;
	for (int i = 0; i < 16; i++) begin
		w[i] = blk[511 - 32*i -: 32];
	end
	for (int i = 16; i < 64; i++) begin
		w[i] = w[i-16] + w[i-7]
			+ (rotr32(w[i-15], 7) ^ rotr32(w[i-15], 18) ^ (w[i-15] >> 3))
			+ (rotr32(w[i-2], 17) ^ rotr32(w[i-2], 19) ^ (w[i-2] >> 10));
	end
	// Working variable A is v[0] and H is v[7].
	for (int k = 0; k < 8; k++) begin
		v[k] = chain[255 - 32*k -: 32];
	end
	for (int i = 0; i < 64; i++) begin
		t1 = v[7] + (rotr32(v[4], 6) ^ rotr32(v[4], 11) ^ rotr32(v[4], 25))
			+ ((v[4] & v[5]) ^ (~v[4] & v[6])) + K_ROUND[i] + w[i];
		t2 = (rotr32(v[0], 2) ^ rotr32(v[0], 13) ^ rotr32(v[0], 22))
			+ ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int k = 7; k > 0; k--) begin
			v[k] = v[k-1];
		end
		v[4] = v[4] + t1;
		v[0] = t1 + t2;
	end
	for (int k = 0; k < 8; k++) begin
		res[255 - 32*k -: 32] = chain[255 - 32*k -: 32] + v[k];
	end
	return res;
endfunction

// The second header chunk is the tail, the nonce and the padding of an 80-byte message.
function automatic logic [255:0] double_hash(input logic [255:0] mid,
		input logic [95:0] tail, input logic [31:0] nonce);
	logic [255:0] hash1;
	hash1 = compress_block(mid, {tail, nonce, 32'h8000_0000, 320'd0, 32'd640});
	return compress_block(INIT_HASH, {hash1, 32'h8000_0000, 192'd0, 32'd256});
endfunction

`endif

//--- verification/tb_miner_top.sv
`timescale 1ns/1ps
`include "sha_cfg.svh"

module tb_miner_top;
	import sha_pkg::*;

	`include "sha_ref_model.svh"

	localparam int LAT = `SHA_CORE_LATENCY;

	logic clk;
	logic rst_n_i;
	logic start_i;
	hash_state_t midstate_i;
	header_tail_t tail_i;
	word_t nonce_start_i;
	word_t nonce_count_i;
	word_t target_i;
	logic found_o;
	word_t found_nonce_o;
	hash_state_t found_hash_o;
	logic done_o;
	logic busy_o;

	// At a falling edge, cyc + 1 is the cycle in which the values now present are sampled.
	int cyc = 0;
	int value_errs = 0;
	int other_errs = 0;
	int done_cyc = 0;
	int busy_from = 0;
	int hits_exp = 0;
	int hits_seen = 0;
	logic [31:0] rng = 32'd46306;
	string test_name;
	word_t exp_nonce_q [$];
	hash_state_t exp_hash_q [$];
	int exp_cyc_q [$];

	miner_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [255:0] random_state();
		logic [255:0] s;
		for (int k = 0; k < 8; k++) begin
			s[32*k +: 32] = next_random();
		end
		return s;
	endfunction

	task automatic report_value(input string sig, input logic [255:0] exp,
			input logic [255:0] act);
		value_errs++;
		$display("ERR %s %s expected %h actual %h", test_name, sig, exp, act);
	endtask

	// Output checks at every falling edge against the expected schedule.
	always @(negedge clk) begin : check_outputs
		int cur;
		cur = cyc + 1;
		if (rst_n_i) begin
			assert (done_o == (cur == done_cyc))
				else report_value("done_o", cur == done_cyc, done_o);
			assert (busy_o == (cur >= busy_from && cur <= done_cyc))
				else report_value("busy_o", cur >= busy_from && cur <= done_cyc, busy_o);
			if (exp_cyc_q.size() > 0 && exp_cyc_q[0] == cur) begin
				assert (found_o) else report_value("found_o", 1'b1, found_o);
			end
			if (found_o && (exp_cyc_q.size() == 0 || exp_cyc_q[0] != cur)) begin
				other_errs++;
				$display("Unexpected found_o in %s at cycle %0d", test_name, cur);
			end else if (found_o) begin
				hits_seen++;
				assert (found_nonce_o == exp_nonce_q[0])
					else report_value("found_nonce_o", exp_nonce_q[0], found_nonce_o);
				assert (found_hash_o == exp_hash_q[0])
					else report_value("found_hash_o", exp_hash_q[0], found_hash_o);
			end
			if (exp_cyc_q.size() > 0 && exp_cyc_q[0] <= cur) begin
				void'(exp_cyc_q.pop_front());
				void'(exp_nonce_q.pop_front());
				void'(exp_hash_q.pop_front());
			end
		end
	end

	task automatic wait_done(input int limit);
		int waited;
		waited = 0;
		while (!done_o && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (!done_o) begin
			other_errs++;
			$display("Timeout in %s: done_o did not pulse within %0d cycles", test_name, limit);
		end
		@(negedge clk);
		assert (hits_seen == hits_exp)
			else report_value("hit count", hits_exp, hits_seen);
	endtask

	// Starts one job, fills the expected schedule and waits for the job to finish.
	task automatic run_job(input string name, input word_t target, input word_t count,
			input bit extra_start);
		word_t n;
		hash_state_t h;
		int t;
		int items;
		test_name = name;
		midstate_i = random_state();
		tail_i[95:64] = next_random();
		tail_i[63:32] = next_random();
		tail_i[31:0] = next_random();
		nonce_start_i = next_random();
		nonce_count_i = count;
		target_i = target;
		start_i = 1'b1;
		t = cyc + 1;
		items = (count == 0) ? 1 : count;
		hits_exp = 0;
		hits_seen = 0;
		for (int i = 0; i < items; i++) begin
			n = nonce_start_i + i;
			h = double_hash(midstate_i, tail_i, n);
			if (h[31:0] <= target) begin
				exp_nonce_q.push_back(n);
				exp_hash_q.push_back(h);
				exp_cyc_q.push_back(t + LAT + 2 + i);
				hits_exp++;
			end
		end
		busy_from = t + 1;
		done_cyc = t + items + LAT + 1;
		@(negedge clk);
		start_i = 1'b0;
		if (extra_start) begin
			// A busy miner must drop this job, which would hit on every nonce.
			repeat (20) @(negedge clk);
			midstate_i = random_state();
			target_i = 32'hffff_ffff;
			start_i = 1'b1;
			@(negedge clk);
			start_i = 1'b0;
		end
		wait_done(items + LAT + 20);
	endtask

	initial begin
		rst_n_i = 1'b0;
		start_i = 1'b0;
		midstate_i = '0;
		tail_i = '0;
		nonce_start_i = '0;
		nonce_count_i = '0;
		target_i = '0;
		test_name = "reset_idle";
		repeat (4) @(negedge clk);
		rst_n_i = 1'b1;
		repeat (12) @(negedge clk);
		run_job("all_hits", 32'hffff_ffff, 8, 1'b0);
		run_job("zero_target", 32'h0, 6, 1'b0);
		run_job("zero_count", 32'h0, 0, 1'b0);
		repeat (2) begin
			run_job("mid_target", 32'h7f00_0000 + (next_random() & 32'h01ff_ffff), 40, 1'b0);
		end
		run_job("ignored_start", 32'h7f80_0000, 8, 1'b1);
		$display("Error counts: %0d value mismatches, %0d other failures",
			value_errs, other_errs);
		if (value_errs + other_errs == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- miner_top.f
+incdir+hdl
+incdir+verification
hdl/sha_pkg.sv
hdl/sha_round_stage.sv
hdl/delay_line.sv
hdl/sha_pad_stage.sv
hdl/sha_standard_pipelined_core.sv
hdl/nonce_feeder.sv
hdl/hit_checker.sv
hdl/miner_top.sv
verification/tb_miner_top.sv
